/* tb.f */
source/icmp_pkg.sv
source/icmp_meta_if.sv
source/icmp_rx_parser.sv
source/icmp_payload_buf.sv
source/icmp_echo_tx.sv
source/icmp_echo_top.sv
verif/icmp_echo_tb.sv

/* Bender.yml */
package:
  name: icmp_echo

sources:
  - files:
      - source/icmp_pkg.sv
      - source/icmp_meta_if.sv
      - source/icmp_rx_parser.sv
      - source/icmp_payload_buf.sv
      - source/icmp_echo_tx.sv
      - source/icmp_echo_top.sv
  - target: test
    files:
      - verif/icmp_echo_tb.sv

/* verif/icmp_echo_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module icmp_echo_tb
  import icmp_pkg::*;
();

  localparam int TIMEOUT_CYC = 40 * (2 * ICMP_MAX_LEN + 20);

  typedef struct packed {
    byte_t     dat;
    logic      sof;
    logic      eof;
    ip_addr_t  dst;
    icmp_len_t len;
  } exp_byte_t;

  logic      clk;
  logic      fsm_rst;
  logic      in_val;
  logic      in_sof;
  logic      in_eof;
  byte_t     in_dat;
  proto_t    in_proto;
  ip_addr_t  in_src_ip;
  ip_addr_t  in_dst_ip;
  icmp_len_t in_len;
  logic      out_val;
  logic      out_sof;
  logic      out_eof;
  byte_t     out_dat;
  ip_addr_t  out_dst_ip;
  icmp_len_t out_len;

  logic      acc_eof;   // Last byte of a request that must be answered
  exp_byte_t exp_q[$];  // Expected reply bytes, in order
  exp_byte_t head;
  logic      head_vld;
  integer    seed;
  int        cyc;
  int        err_val;
  int        err_other;

  icmp_echo_top dut0 (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .in_val     (in_val),
    .in_sof     (in_sof),
    .in_eof     (in_eof),
    .in_dat     (in_dat),
    .in_proto   (in_proto),
    .in_src_ip  (in_src_ip),
    .in_dst_ip  (in_dst_ip),
    .in_len     (in_len),
    .out_val    (out_val),
    .out_sof    (out_sof),
    .out_eof    (out_eof),
    .out_dat    (out_dat),
    .out_dst_ip (out_dst_ip),
    .out_len    (out_len)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  // Reply checksum, request checksum plus 0x0800 in ones' complement
  function automatic word16_t reply_checksum(input word16_t req);
    logic [31:0] s;
    s = 32'(req) + 32'h0000_0800;
    s = (s & 32'h0000_FFFF) + (s >> 16);
    return s[15:0];
  endfunction

  task automatic idle_cycle();
    @(posedge clk);
    in_val  <= 1'b0;
    in_sof  <= 1'b0;
    in_eof  <= 1'b0;
    acc_eof <= 1'b0;
  endtask

  // Sends one packet of nbytes bytes, queues the reply when acc is set
  task automatic send_pkt(input proto_t proto, input ip_addr_t dst, input byte_t typ,
                          input byte_t code, input icmp_len_t len, input int nbytes,
                          input bit gaps, input bit acc);
    byte_t     pkt [ICMP_MAX_LEN + 8];
    ip_addr_t  src;
    word16_t   cks;
    exp_byte_t e;
    int        i;
    int        g;
    src = $random(seed);
    for (i = 0; i < ICMP_MAX_LEN + 8; i++) begin
      pkt[i] = byte_t'($random(seed));  // Cks, id, seq and payload
    end
    pkt[0] = typ;
    pkt[1] = code;
    cks    = reply_checksum({pkt[2], pkt[3]});
    if (acc) begin
      for (i = 0; i < int'(len); i++) begin
        e.dat = (i == 0) ? 8'h00 : (i == 2) ? cks[15:8] : (i == 3) ? cks[7:0] : pkt[i];
        e.sof = (i == 0);
        e.eof = (i == len - 1);
        e.dst = src;
        e.len = len;
        exp_q.push_back(e);
      end
    end
    for (i = 0; i < nbytes; i++) begin
      g = (gaps && (i > 0)) ? {$random(seed)} % 3 : 0;
      repeat (g) idle_cycle();
      @(posedge clk);
      in_val    <= 1'b1;
      in_sof    <= (i == 0);
      in_eof    <= (i == nbytes - 1);
      in_dat    <= pkt[i];
      in_proto  <= proto;
      in_src_ip <= src;
      in_dst_ip <= dst;
      in_len    <= len;
      acc_eof   <= acc && (i == nbytes - 1);
    end
    idle_cycle();
  endtask

  // Out_val here is still the value from before the edge
  task automatic wait_idle();
    @(posedge clk);
    while ((exp_q.size() != 0) || out_val) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
  endtask

  always @(posedge clk) begin
    if (!fsm_rst && out_val && (exp_q.size() != 0)) begin
      void'(exp_q.pop_front());
    end
    head_vld <= (exp_q.size() != 0);
    if (exp_q.size() != 0) begin
      head <= exp_q[0];
    end
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYC) begin
      $display("Timeout after %0d cycles, run did not finish", cyc);
      $display("Test FAILED");
      $finish;
    end
  end

  a_expected: assert property (@(posedge clk) disable iff (fsm_rst) out_val |-> head_vld)
    else begin
      err_other = err_other + 1;
      $display("Output byte at %0t while no reply was expected", $time);
    end

  a_dat: assert property (@(posedge clk) disable iff (fsm_rst)
    (out_val && head_vld) |-> (out_dat == head.dat))
    else begin
      err_val = err_val + 1;
      $display("FAILED t=%0t out_dat exp %02h got %02h",
               $time, $sampled(head.dat), $sampled(out_dat));
    end

  a_sof: assert property (@(posedge clk) disable iff (fsm_rst)
    (out_val && head_vld) |-> (out_sof == head.sof))
    else begin
      err_val = err_val + 1;
      $display("FAILED t=%0t out_sof exp %0b got %0b",
               $time, $sampled(head.sof), $sampled(out_sof));
    end

  a_eof: assert property (@(posedge clk) disable iff (fsm_rst)
    (out_val && head_vld) |-> (out_eof == head.eof))
    else begin
      err_val = err_val + 1;
      $display("FAILED t=%0t out_eof exp %0b got %0b",
               $time, $sampled(head.eof), $sampled(out_eof));
    end

  a_dst: assert property (@(posedge clk) disable iff (fsm_rst)
    (out_val && head_vld) |-> (out_dst_ip == head.dst))
    else begin
      err_val = err_val + 1;
      $display("FAILED t=%0t out_dst_ip exp %08h got %08h",
               $time, $sampled(head.dst), $sampled(out_dst_ip));
    end

  a_len: assert property (@(posedge clk) disable iff (fsm_rst)
    (out_val && head_vld) |-> (out_len == head.len))
    else begin
      err_val = err_val + 1;
      $display("FAILED t=%0t out_len exp %0d got %0d",
               $time, $sampled(head.len), $sampled(out_len));
    end

  a_no_gap: assert property (@(posedge clk) disable iff (fsm_rst)
    (out_val && !out_eof) |=> out_val)
    else begin
      err_other = err_other + 1;
      $display("Gap inside the reply stream at %0t", $time);
    end

  // Fixed latency from request eof to reply sof
  a_sof_time: assert property (@(posedge clk) disable iff (fsm_rst)
    (in_val && in_eof && acc_eof) |-> ##3 (out_val && out_sof))
    else begin
      err_other = err_other + 1;
      $display("Reply did not start 3 cycles after request end, at %0t", $time);
    end

  a_rst_quiet: assert property (@(posedge clk)
    fsm_rst |=> (!out_val && !out_sof && !out_eof))
    else begin
      err_other = err_other + 1;
      $display("Output active during or right after reset at %0t", $time);
    end

  initial begin
    int        k;
    icmp_len_t len;
    seed      = 93600;
    fsm_rst   = 1'b1;
    in_val    = 1'b0;
    in_sof    = 1'b0;
    in_eof    = 1'b0;
    in_dat    = '0;
    in_proto  = '0;
    in_src_ip = '0;
    in_dst_ip = '0;
    in_len    = '0;
    acc_eof   = 1'b0;
    head_vld  = 1'b0;
    head      = '0;
    cyc       = 0;
    err_val   = 0;
    err_other = 0;
    repeat (8) @(posedge clk);
    fsm_rst <= 1'b0;
    repeat (2) @(posedge clk);

    // Valid requests, empty, full and random payload
    send_pkt(PROTO_ICMP, LOCAL_IP, TYPE_ECHO_REQ, 8'h00, 16'd8, 8, 1'b0, 1'b1);
    wait_idle();
    send_pkt(PROTO_ICMP, LOCAL_IP, TYPE_ECHO_REQ, 8'h00, 16'd72, 72, 1'b0, 1'b1);
    wait_idle();
    for (k = 0; k < 10; k++) begin
      len = 16'd8 + icmp_len_t'({$random(seed)} % 65);
      send_pkt(PROTO_ICMP, LOCAL_IP, TYPE_ECHO_REQ, 8'h00, len, int'(len), 1'b0, 1'b1);
      wait_idle();
    end

    // Filtered packets, none of these may answer
    send_pkt(8'd6, LOCAL_IP, TYPE_ECHO_REQ, 8'h00, 16'd20, 20, 1'b0, 1'b0);
    send_pkt(PROTO_ICMP, LOCAL_IP ^ 32'h1, TYPE_ECHO_REQ, 8'h00, 16'd20, 20, 1'b0, 1'b0);
    send_pkt(PROTO_ICMP, LOCAL_IP, 8'd13, 8'h00, 16'd20, 20, 1'b0, 1'b0);
    send_pkt(PROTO_ICMP, LOCAL_IP, TYPE_ECHO_REQ, 8'h01, 16'd20, 20, 1'b0, 1'b0);
    send_pkt(PROTO_ICMP, LOCAL_IP, TYPE_ECHO_REQ, 8'h00, 16'd30, 31, 1'b0, 1'b0);
    send_pkt(PROTO_ICMP, LOCAL_IP, TYPE_ECHO_REQ, 8'h00, 16'd30, 29, 1'b0, 1'b0);
    send_pkt(PROTO_ICMP, LOCAL_IP, TYPE_ECHO_REQ, 8'h00, 16'd6, 6, 1'b0, 1'b0);
    send_pkt(PROTO_ICMP, LOCAL_IP, TYPE_ECHO_REQ, 8'h00, 16'd73, 73, 1'b0, 1'b0);
    wait_idle();

    // Second request while the first reply streams
    send_pkt(PROTO_ICMP, LOCAL_IP, TYPE_ECHO_REQ, 8'h00, 16'd12, 12, 1'b0, 1'b1);
    while (!out_val) begin
      @(posedge clk);
    end
    send_pkt(PROTO_ICMP, LOCAL_IP, TYPE_ECHO_REQ, 8'h00, 16'd48, 48, 1'b0, 1'b0);
    wait_idle();
    send_pkt(PROTO_ICMP, LOCAL_IP, TYPE_ECHO_REQ, 8'h00, 16'd24, 24, 1'b0, 1'b1);
    wait_idle();

    // Gaps in the request stream
    for (k = 0; k < 4; k++) begin
      len = 16'd8 + icmp_len_t'({$random(seed)} % 65);
      send_pkt(PROTO_ICMP, LOCAL_IP, TYPE_ECHO_REQ, 8'h00, len, int'(len), 1'b1, 1'b1);
      wait_idle();
    end

    repeat (4) @(posedge clk);
    if (exp_q.size() != 0) begin
      err_other = err_other + 1;
      $display("Reply missing, %0d expected bytes never came out", exp_q.size());
    end
    $display("Errors: %0d wrong values, %0d other failures", err_val, err_other);
    if ((err_val == 0) && (err_other == 0)) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* source/icmp_echo_top.sv */
`timescale 1ns/1ps
`default_nettype none

module icmp_echo_top
  import icmp_pkg::*;
(
  input  logic      clk,
  input  logic      fsm_rst,
  input  logic      in_val,
  input  logic      in_sof,
  input  logic      in_eof,
  input  byte_t     in_dat,
  input  proto_t    in_proto,
  input  ip_addr_t  in_src_ip,
  input  ip_addr_t  in_dst_ip,
  input  icmp_len_t in_len,
  output logic      out_val,
  output logic      out_sof,
  output logic      out_eof,
  output byte_t     out_dat,
  output ip_addr_t  out_dst_ip,
  output icmp_len_t out_len
);

  logic      wr_en;
  buf_addr_t wr_addr;
  byte_t     wr_dat;
  buf_addr_t rd_addr;
  byte_t     rd_dat;

  icmp_meta_if meta0 ();  // Request fields, parser to transmitter

  icmp_rx_parser rx0 (
    .clk       (clk),
    .fsm_rst   (fsm_rst),
    .in_val    (in_val),
    .in_sof    (in_sof),
    .in_eof    (in_eof),
    .in_dat    (in_dat),
    .in_proto  (in_proto),
    .in_src_ip (in_src_ip),
    .in_dst_ip (in_dst_ip),
    .in_len    (in_len),
    .meta      (meta0),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_dat    (wr_dat)
  );

  icmp_payload_buf buf0 (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_dat  (wr_dat),
    .rd_addr (rd_addr),
    .rd_dat  (rd_dat)
  );

  icmp_echo_tx tx0 (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .meta       (meta0),
    .rd_addr    (rd_addr),
    .rd_dat     (rd_dat),
    .out_val    (out_val),
    .out_sof    (out_sof),
    .out_eof    (out_eof),
    .out_dat    (out_dat),
    .out_dst_ip (out_dst_ip),
    .out_len    (out_len)
  );

endmodule

`default_nettype wire

/* source/icmp_echo_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module icmp_echo_tx
  import icmp_pkg::*;
(
  input  logic         clk,
  input  logic         fsm_rst,
  icmp_meta_if.echo_tx meta,
  output buf_addr_t    rd_addr,
  input  byte_t        rd_dat,
  output logic         out_val,
  output logic         out_sof,
  output logic         out_eof,
  output byte_t        out_dat,
  output ip_addr_t     out_dst_ip,
  output icmp_len_t    out_len
);

  tx_state_t state;
  icmp_len_t tx_cnt;  // Index of byte being issued
  icmp_len_t len_q;
  ip_addr_t  dst_q;
  byte_t     code_q;
  word16_t   cks_q;   // Already adjusted for the reply type
  word16_t   id_q;
  word16_t   seq_q;
  byte_t     hdr_byte;
  logic      last;

  // Ones' complement add with end-around carry
  function automatic word16_t ones_add(input word16_t a, input word16_t b);
    logic [16:0] sum;
    sum = {1'b0, a} + {1'b0, b};
    return sum[15:0] + word16_t'(sum[16]);
  endfunction

  assign last = (tx_cnt == len_q - icmp_len_t'(1));

  // Address runs one byte ahead of the output to hide read latency
  assign rd_addr = buf_addr_t'(tx_cnt - icmp_len_t'(ICMP_HDR_LEN - 1));

  assign meta.busy  = (state != TX_IDLE) || out_val;
  assign out_dst_ip = dst_q;
  assign out_len    = len_q;

  always_comb begin
    case (tx_cnt[2:0])  // Network byte order
      3'd0: hdr_byte = TYPE_ECHO_REPLY;
      3'd1: hdr_byte = code_q;
      3'd2: hdr_byte = cks_q[15:8];
      3'd3: hdr_byte = cks_q[7:0];
      3'd4: hdr_byte = id_q[15:8];
      3'd5: hdr_byte = id_q[7:0];
      3'd6: hdr_byte = seq_q[15:8];
      default: hdr_byte = seq_q[7:0];
    endcase
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state   <= TX_IDLE;
      tx_cnt  <= '0;
      out_val <= 1'b0;
      out_sof <= 1'b0;
      out_eof <= 1'b0;
    end else begin
      out_val <= 1'b0;
      out_sof <= 1'b0;
      out_eof <= 1'b0;
      unique case (state)
        TX_IDLE: begin
          tx_cnt <= '0;
          if (meta.val) begin
            state <= TX_HDR;
          end
        end
        TX_HDR: begin
          out_val <= 1'b1;
          out_sof <= (tx_cnt == '0);
          out_eof <= last;
          tx_cnt  <= tx_cnt + icmp_len_t'(1);
          if (last) begin
            state <= TX_IDLE;  // Empty payload
          end else if (tx_cnt == icmp_len_t'(ICMP_HDR_LEN - 1)) begin
            state <= TX_PLD;
          end
        end
        TX_PLD: begin
          out_val <= 1'b1;
          out_eof <= last;
          tx_cnt  <= tx_cnt + icmp_len_t'(1);
          if (last) begin
            state <= TX_IDLE;
          end
        end
        default: begin
          state <= TX_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    out_dat <= (state == TX_PLD) ? rd_dat : hdr_byte;
    if ((state == TX_IDLE) && meta.val) begin
      dst_q  <= meta.src_ip;
      code_q <= meta.code;
      cks_q  <= ones_add(meta.cks, CKS_TYPE_ADJ);
      id_q   <= meta.id;
      seq_q  <= meta.seq;
      len_q  <= meta.pld_len + icmp_len_t'(ICMP_HDR_LEN);
    end
  end

  // Sof lands two cycles after the strobe
  a_flags_val: assert property (
    @(posedge clk) disable iff (fsm_rst)
    (out_sof || out_eof) |-> out_val && (!out_sof || $past(meta.val, 2))
  ) else $error("sof or eof without val, or sof out of its slot");

  // Parser must hold off while a reply is running
  a_no_overlap: assert property (
    @(posedge clk) disable iff (fsm_rst)
    meta.val |-> !meta.busy
  ) else $error("meta strobe while busy");

endmodule

`default_nettype wire

/* source/icmp_payload_buf.sv */
`timescale 1ns/1ps
`default_nettype none

module icmp_payload_buf
  import icmp_pkg::*;
(
  input  logic      clk,
  input  logic      wr_en,
  input  buf_addr_t wr_addr,
  input  byte_t     wr_dat,
  input  buf_addr_t rd_addr,
  output byte_t     rd_dat
);

  byte_t mem [ICMP_MAX_PLD];  // One echo payload

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_dat;
    end
  end

  // Registered read, data one cycle after address
  always_ff @(posedge clk) begin
    rd_dat <= mem[rd_addr];
  end

endmodule

`default_nettype wire

/* source/icmp_rx_parser.sv */
`timescale 1ns/1ps
`default_nettype none

module icmp_rx_parser
  import icmp_pkg::*;
(
  input  logic        clk,
  input  logic        fsm_rst,
  input  logic        in_val,
  input  logic        in_sof,
  input  logic        in_eof,
  input  byte_t       in_dat,
  input  proto_t      in_proto,
  input  ip_addr_t    in_src_ip,
  input  ip_addr_t    in_dst_ip,
  input  icmp_len_t   in_len,
  icmp_meta_if.parser meta,
  output logic        wr_en,
  output buf_addr_t   wr_addr,
  output byte_t       wr_dat
);

  rx_state_t state;
  rx_state_t cur_st;    // State that owns the byte on in_dat
  rx_state_t adv_st;    // State after this byte, ignoring eof
  icmp_len_t byte_cnt;  // Bytes taken so far in this packet
  icmp_len_t byte_idx;
  icmp_len_t byte_num;
  icmp_len_t pld_off;
  logic      len_ok;
  logic      pkt_ok;
  logic      hdr_bad;
  logic      done_ok;

  byte_t [ICMP_HDR_LEN-1:0] hdr;      // Shift register, first byte ends up on top
  byte_t [ICMP_HDR_LEN-1:0] hdr_now;  // Includes the current byte while in header

  assign byte_idx = in_sof ? '0 : byte_cnt;
  assign byte_num = byte_idx + icmp_len_t'(1);
  assign pld_off  = byte_idx - icmp_len_t'(ICMP_HDR_LEN);

  assign len_ok = (in_len >= icmp_len_t'(ICMP_HDR_LEN)) &&
                  (in_len <= icmp_len_t'(ICMP_MAX_LEN));

  // A strobe in flight counts as busy, busy only rises a cycle later
  assign pkt_ok = (in_proto == PROTO_ICMP) && (in_dst_ip == LOCAL_IP) && len_ok &&
                  !meta.busy && !meta.val;

  assign cur_st = in_sof ? (pkt_ok ? RX_HDR : RX_DROP) : state;

  // Type is already in hdr[0] when the code byte arrives
  assign hdr_bad = (byte_idx == icmp_len_t'(1)) &&
                   ((hdr[0] != TYPE_ECHO_REQ) || (in_dat != 8'h00));

  assign hdr_now = (cur_st == RX_HDR) ? {hdr[ICMP_HDR_LEN-2:0], in_dat} : hdr;

  always_comb begin
    adv_st = cur_st;
    unique case (cur_st)
      RX_HDR: begin
        if (hdr_bad) begin
          adv_st = RX_DROP;
        end else if (byte_idx == icmp_len_t'(ICMP_HDR_LEN - 1)) begin
          adv_st = RX_PLD;
        end
      end
      RX_PLD: begin
        if (byte_idx >= in_len) begin
          adv_st = RX_DROP;  // Longer than announced
        end
      end
      default: begin
        adv_st = cur_st;
      end
    endcase
  end

  // Covers zero payload too, the last header byte already moves to RX_PLD
  assign done_ok = in_val && in_eof && (adv_st == RX_PLD) && (byte_num == in_len);

  assign wr_en   = in_val && (cur_st == RX_PLD) && (adv_st == RX_PLD);
  assign wr_addr = buf_addr_t'(pld_off);
  assign wr_dat  = in_dat;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state    <= RX_IDLE;
      byte_cnt <= '0;
      meta.val <= 1'b0;
    end else begin
      meta.val <= done_ok;
      if (in_val) begin
        state    <= in_eof ? RX_IDLE : adv_st;
        byte_cnt <= byte_num;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_val && (cur_st == RX_HDR)) begin
      hdr <= hdr_now;
    end
    if (done_ok) begin
      meta.src_ip  <= in_src_ip;
      meta.code    <= hdr_now[6];
      meta.cks     <= hdr_now[5:4];
      meta.id      <= hdr_now[3:2];
      meta.seq     <= hdr_now[1:0];
      meta.pld_len <= in_len - icmp_len_t'(ICMP_HDR_LEN);
    end
  end

  // One request, one strobe
  a_meta_pulse: assert property (
    @(posedge clk) disable iff (fsm_rst)
    meta.val |=> !meta.val
  ) else $error("meta val held for more than one cycle");

  // Payload writes stay inside the buffer and never overlap a reply
  a_wr_in_pld: assert property (
    @(posedge clk) disable iff (fsm_rst)
    wr_en |-> (state == RX_PLD) && (pld_off < icmp_len_t'(ICMP_MAX_PLD)) && !meta.busy
  ) else $error("buffer write outside payload or during a reply");

endmodule

`default_nettype wire

/* source/icmp_meta_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface icmp_meta_if
  import icmp_pkg::*;
();

  logic      val;      // One-cycle strobe, fields valid with it
  ip_addr_t  src_ip;   // Requester, becomes reply destination
  byte_t     code;
  word16_t   cks;      // Checksum as received
  word16_t   id;
  word16_t   seq;
  icmp_len_t pld_len;  // Payload bytes only
  logic      busy;     // Reply in progress

  modport parser (
    output val, src_ip, code, cks, id, seq, pld_len,
    input  busy
  );

  modport echo_tx (
    input  val, src_ip, code, cks, id, seq, pld_len,
    output busy
  );

endinterface

`default_nettype wire

/* source/icmp_pkg.sv */
`default_nettype none

package icmp_pkg;

  // Sizes
  localparam int ICMP_HDR_LEN = 8;   // Type, code, cks, id, seq
  localparam int ICMP_MAX_PLD = 64;  // Also buffer depth
  localparam int ICMP_MAX_LEN = ICMP_HDR_LEN + ICMP_MAX_PLD;
  localparam int BUF_AW       = $clog2(ICMP_MAX_PLD);

  typedef logic [7:0]        byte_t;
  typedef logic [31:0]       ip_addr_t;
  typedef logic [7:0]        proto_t;
  typedef logic [15:0]       icmp_len_t;  // Header plus payload
  typedef logic [15:0]       word16_t;
  typedef logic [BUF_AW-1:0] buf_addr_t;

  localparam proto_t   PROTO_ICMP      = 8'd1;
  localparam ip_addr_t LOCAL_IP        = 32'hC0A8_0A01;  // 192.168.10.1
  localparam byte_t    TYPE_ECHO_REQ   = 8'd8;
  localparam byte_t    TYPE_ECHO_REPLY = 8'd0;

  // Type byte sits in the upper half of the first word, so 8 -> 0 is 0x0800
  localparam word16_t  CKS_TYPE_ADJ    = 16'h0800;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_HDR,
    RX_PLD,
    RX_DROP
  } rx_state_t;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_HDR,
    TX_PLD
  } tx_state_t;

endpackage

`default_nettype wire
